/* verilog.f */
+incdir+testbench
src/mem_test_pkg.sv
src/test_launcher.sv
src/mem_test_master.sv
src/req_arbiter.sv
src/mem_bank.sv
src/resp_router.sv
src/mem_test_top.sv
testbench/tb_mem_test_top.sv

/* testbench/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Sum of base+i for i in 0..num_words-1 modulo 2**32.
function automatic logic [31:0] expected_checksum(input logic [31:0] base,
                                                  input int          num_words);
  logic [31:0] scaled;
  logic [31:0] ramp;
  scaled = 32'(num_words) * base;
  ramp   = 32'((num_words * (num_words - 1)) / 2);
  return scaled + ramp;
endfunction

// Every word read back should match.
function automatic logic [7:0] expected_mismatch();
  return 8'h00;
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Random source.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Fibonacci LFSR with taps 32 22 2 1.
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  logic fb;
  fb = state[31] ^ state[21] ^ state[1] ^ state[0];
  return {state[30:0], fb};
endfunction

`endif

/* testbench/tb_mem_test_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mem_test_top;

  `include "tb_model.svh"

  localparam int NUM_MASTERS = 4;
  localparam int NUM_WORDS   = 16;
  localparam int NUM_CMDS    = 12;
  localparam int TIMEOUT_CYCLES = NUM_CMDS * NUM_MASTERS * 2 * NUM_WORDS * 4 + 2000;

  logic                                 clk_i;
  logic                                 reset_i;
  logic                                 cmd_req_i;
  mem_test_pkg::test_cmd_s              cmd_i;
  logic                                 cmd_ack_o;
  logic                                 stall_i;
  logic [NUM_MASTERS-1:0]               done_o;
  logic [NUM_MASTERS-1:0][7:0]          mismatch_o;
  logic [NUM_MASTERS-1:0][31:0]         checksum_o;

  logic [31:0] lfsr_r;
  logic        stall_en;
  int          cycle_cnt;
  int          errors;
  int          test_start;
  int          tests_run;
  int          tests_failed;

  mem_test_top i_mem_test_top (
    .clk_i, .reset_i, .cmd_req_i, .cmd_i, .cmd_ack_o, .stall_i,
    .done_o, .mismatch_o, .checksum_o
  );

  always #10 clk_i = ~clk_i;

  // Watchdog on the whole run.
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the test did not finish", cycle_cnt);
      $display("Checks failed");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_r = lfsr_next(lfsr_r);
      val    = {val[30:0], lfsr_r[0]};
    end
  endtask

  // Step to the next falling edge and drive stall there.
  task automatic tick();
    logic [31:0] r;
    @(negedge clk_i);
    if (stall_en) begin
      take_bits(2, r);
      stall_i = (r[1:0] == 2'b00);
    end else begin
      stall_i = 1'b0;
    end
  endtask

  task automatic send_cmd(input logic [1:0] target, input logic [31:0] base,
                          input logic was_busy);
    assert (!cmd_ack_o) else begin
      $display("cmd_ack_o was high before cmd_req_i was raised");
      errors++;
    end
    cmd_i.target = target;
    cmd_i.base   = base;
    cmd_req_i    = 1'b1;
    tick();
    while (!cmd_ack_o) tick();
    // The master must have finished before a re-target is acked.
    if (was_busy) begin
      assert (done_o[target]) else begin
        $display("cmd_ack_o rose while master %0d was still busy", target);
        errors++;
      end
    end
    cmd_req_i = 1'b0;
    tick();
    assert (!cmd_ack_o) else begin
      $display("cmd_ack_o did not fall one cycle after cmd_req_i fell");
      errors++;
    end
  endtask

  task automatic random_gap();
    logic [31:0] r;
    take_bits(2, r);
    repeat (r[1:0]) tick();
  endtask

  task automatic check_master(input int m, input logic [31:0] base);
    logic [31:0] exp_sum;
    exp_sum = expected_checksum(base, NUM_WORDS);
    assert (mismatch_o[m] == expected_mismatch()) else begin
      $display("Error: mismatch_o[%0d] got %h expected %h", m, mismatch_o[m],
               expected_mismatch());
      errors++;
    end
    assert (checksum_o[m] == exp_sum) else begin
      $display("Error: checksum_o[%0d] got %h expected %h", m, checksum_o[m], exp_sum);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_start) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - test_start);
      tests_failed++;
    end
    test_start = errors;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    logic [31:0] r;
    logic [31:0] bases [NUM_MASTERS];
    logic [1:0]  t;
    clk_i        = 1'b0;
    reset_i      = 1'b1;
    cmd_req_i    = 1'b0;
    cmd_i        = '0;
    stall_i      = 1'b0;
    stall_en     = 1'b0;
    lfsr_r       = 32'ha0ba;
    cycle_cnt    = 0;
    errors       = 0;
    test_start   = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (2) tick();
    reset_i = 1'b0;
    tick();

    assert (done_o == '0 && cmd_ack_o == 1'b0) else begin
      $display("Error: done_o got %h cmd_ack_o got %h expected 0", done_o, cmd_ack_o);
      errors++;
    end
    assert (mismatch_o == '0 && checksum_o == '0) else begin
      $display("Error: mismatch_o got %h checksum_o got %h expected 0",
               mismatch_o, checksum_o);
      errors++;
    end
    end_test("Test 1 after reset");

    take_bits(2, r);
    t = r[1:0];
    take_bits(32, bases[t]);
    send_cmd(t, bases[t], 1'b0);
    while (!done_o[t]) tick();
    check_master(t, bases[t]);
    assert ((done_o & ~(NUM_MASTERS'(1) << t)) == '0) else begin
      $display("Error: done_o got %h expected only bit %0d", done_o, t);
      errors++;
    end
    end_test("Test 2 single master");

    // Two passes over all masters with random stall in the second.
    for (int pass = 0; pass < 2; pass++) begin
      stall_en = (pass == 1);
      for (int m = 0; m < NUM_MASTERS; m++) begin
        take_bits(32, bases[m]);
        send_cmd(2'(m), bases[m], 1'b0);
        random_gap();
      end
      while (done_o != '1) tick();
      for (int m = 0; m < NUM_MASTERS; m++) check_master(m, bases[m]);
      end_test(pass == 0 ? "Test 3 all masters" : "Test 4 random stall");
    end
    stall_en = 1'b0;
    tick();

    take_bits(2, r);
    t = r[1:0];
    take_bits(32, bases[t]);
    send_cmd(t, bases[t], 1'b0);
    assert (!done_o[t]) else begin
      $display("Error: done_o[%0d] got %h expected 0", t, done_o[t]);
      errors++;
    end
    while (!done_o[t]) tick();
    check_master(t, bases[t]);
    end_test("Test 5 restart");

    // Re-target a master right after starting it.
    take_bits(2, r);
    t = r[1:0];
    take_bits(32, bases[t]);
    send_cmd(t, bases[t], 1'b0);
    take_bits(32, bases[t]);
    send_cmd(t, bases[t], 1'b1);
    while (!done_o[t]) tick();
    check_master(t, bases[t]);
    end_test("Test 6 handshake");

    $display("Tests run %0d, tests failed %0d, errors %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src/mem_test_top.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_test_top #(
  parameter int NUM_MASTERS = 4,
  parameter int NUM_WORDS   = 16
) (
  input  logic                                              clk_i,
  input  logic                                              reset_i,
  input  logic                                              cmd_req_i,
  input  mem_test_pkg::test_cmd_s                           cmd_i,
  output logic                                              cmd_ack_o,
  input  logic                                              stall_i,
  output logic [NUM_MASTERS-1:0]                            done_o,
  output logic [NUM_MASTERS-1:0][7:0]                       mismatch_o,
  output logic [NUM_MASTERS-1:0][mem_test_pkg::DATA_W-1:0]  checksum_o
);

  logic [NUM_MASTERS-1:0]           busy;
  logic [NUM_MASTERS-1:0]           start;
  logic [mem_test_pkg::DATA_W-1:0]  base;

  logic [NUM_MASTERS-1:0]                    mst_req_valid;
  mem_test_pkg::mem_req_s [NUM_MASTERS-1:0]  mst_req;
  logic [NUM_MASTERS-1:0]                    mst_req_ready;
  logic [NUM_MASTERS-1:0]                    mst_resp_valid;
  mem_test_pkg::mem_resp_s                   mst_resp;
  logic [NUM_MASTERS-1:0]                    mst_resp_ready;

  logic                     bank_req_valid;
  mem_test_pkg::mem_req_s   bank_req;
  logic                     bank_req_ready;
  logic                     bank_resp_valid;
  mem_test_pkg::mem_resp_s  bank_resp;
  logic                     bank_resp_ready;

  test_launcher #(.NUM_MASTERS(NUM_MASTERS)) i_launcher (
    .clk_i, .reset_i, .cmd_req_i, .cmd_i, .cmd_ack_o,
    .busy_i(busy), .start_o(start), .base_o(base)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test masters.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar g = 0; g < NUM_MASTERS; g++) begin : g_master
    mem_test_master #(.NUM_WORDS(NUM_WORDS), .MASTER_ID(g)) i_master (
      .clk_i, .reset_i,
      .start_i(start[g]), .base_i(base), .busy_o(busy[g]),
      .req_valid_o(mst_req_valid[g]), .req_o(mst_req[g]), .req_ready_i(mst_req_ready[g]),
      .resp_valid_i(mst_resp_valid[g]), .resp_i(mst_resp),
      .resp_ready_o(mst_resp_ready[g]),
      .done_o(done_o[g]), .mismatch_o(mismatch_o[g]), .checksum_o(checksum_o[g])
    );
  end

  req_arbiter #(.NUM_MASTERS(NUM_MASTERS)) i_arbiter (
    .clk_i, .reset_i,
    .valid_i(mst_req_valid), .req_i(mst_req), .ready_o(mst_req_ready),
    .valid_o(bank_req_valid), .req_o(bank_req), .ready_i(bank_req_ready)
  );

  mem_bank i_bank (
    .clk_i, .reset_i, .stall_i,
    .req_valid_i(bank_req_valid), .req_i(bank_req), .req_ready_o(bank_req_ready),
    .resp_valid_o(bank_resp_valid), .resp_o(bank_resp), .resp_ready_i(bank_resp_ready)
  );

  resp_router #(.NUM_MASTERS(NUM_MASTERS)) i_router (
    .valid_i(bank_resp_valid), .resp_i(bank_resp), .ready_o(bank_resp_ready),
    .valid_o(mst_resp_valid), .resp_o(mst_resp), .ready_i(mst_resp_ready)
  );

endmodule

`default_nettype wire

/* src/resp_router.sv */
`timescale 1ns/10ps
`default_nettype none

module resp_router #(
  parameter int NUM_MASTERS = 4
) (
  input  logic                     valid_i,
  input  mem_test_pkg::mem_resp_s  resp_i,
  output logic                     ready_o,
  output logic [NUM_MASTERS-1:0]   valid_o,
  output mem_test_pkg::mem_resp_s  resp_o,
  input  logic [NUM_MASTERS-1:0]   ready_i
);

  logic [NUM_MASTERS-1:0] dest_oh;

  // Source id picks the one master to see the reply.
  assign dest_oh = NUM_MASTERS'(1) << resp_i.src_id;
  assign valid_o = valid_i ? dest_oh : '0;
  assign resp_o  = resp_i;
  assign ready_o = |(dest_oh & ready_i);

  a_src_in_range: assert final (!valid_i || (int'(resp_i.src_id) < NUM_MASTERS));

endmodule

`default_nettype wire

/* src/mem_bank.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_bank (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     stall_i,
  input  logic                     req_valid_i,
  input  mem_test_pkg::mem_req_s   req_i,
  output logic                     req_ready_o,
  output logic                     resp_valid_o,
  output mem_test_pkg::mem_resp_s  resp_o,
  input  logic                     resp_ready_i
);

  localparam int DEPTH = 2 ** mem_test_pkg::ADDR_W;

  logic [mem_test_pkg::DATA_W-1:0] mem_r [DEPTH];

  mem_test_pkg::mem_resp_s resp_r;
  logic                    resp_valid_r;
  logic                    accept;
  logic                    is_store;

  // Room exists when the response slot is empty or drains now.
  assign req_ready_o = !stall_i && (!resp_valid_r || resp_ready_i);
  assign accept      = req_valid_i && req_ready_o;
  assign is_store    = (req_i.op == mem_test_pkg::OP_STORE);

  always_ff @(posedge clk_i) begin
    if (accept && is_store) mem_r[req_i.addr] <= req_i.data;
  end

  always_ff @(posedge clk_i) begin
    if (accept && !is_store) begin
      resp_r.src_id <= req_i.src_id;
      resp_r.data   <= mem_r[req_i.addr];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_valid_r <= 1'b0;
    end else if (accept && !is_store) begin
      resp_valid_r <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_r <= 1'b0;
    end
  end

  assign resp_valid_o = resp_valid_r;
  assign resp_o       = resp_r;

endmodule

`default_nettype wire

/* src/req_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module req_arbiter #(
  parameter int NUM_MASTERS = 4
) (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  logic [NUM_MASTERS-1:0]                    valid_i,
  input  mem_test_pkg::mem_req_s [NUM_MASTERS-1:0]  req_i,
  output logic [NUM_MASTERS-1:0]                    ready_o,
  output logic                                      valid_o,
  output mem_test_pkg::mem_req_s                    req_o,
  input  logic                                      ready_i
);

  localparam int IDX_W = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;

  logic [IDX_W-1:0]       ptr_r;
  logic [IDX_W-1:0]       sel;
  logic [NUM_MASTERS-1:0] grant;
  int                     idx;

  // Walk from the far end so the nearest requester to the pointer wins.
  always_comb begin
    grant = '0;
    sel   = ptr_r;
    idx   = 0;
    for (int i = NUM_MASTERS - 1; i >= 0; i--) begin
      idx = (int'(ptr_r) + i) % NUM_MASTERS;
      if (valid_i[idx]) begin
        grant      = '0;
        grant[idx] = 1'b1;
        sel        = IDX_W'(idx);
      end
    end
  end

  assign valid_o = |valid_i;
  assign req_o   = req_i[sel];
  assign ready_o = grant & {NUM_MASTERS{ready_i}};

  // Rotate past the winner after each transfer.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_r <= '0;
    end else if (valid_o && ready_i) begin
      ptr_r <= (int'(sel) == NUM_MASTERS - 1) ? '0 : sel + 1'b1;
    end
  end

  a_grant_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(grant) && (valid_o == |grant));

endmodule

`default_nettype wire

/* src/mem_test_master.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_test_master #(
  parameter int NUM_WORDS = 16,
  parameter int MASTER_ID = 0
) (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              start_i,
  input  logic [mem_test_pkg::DATA_W-1:0]   base_i,
  output logic                              busy_o,
  output logic                              req_valid_o,
  output mem_test_pkg::mem_req_s            req_o,
  input  logic                              req_ready_i,
  input  logic                              resp_valid_i,
  input  mem_test_pkg::mem_resp_s           resp_i,
  output logic                              resp_ready_o,
  output logic                              done_o,
  output logic [7:0]                        mismatch_o,
  output logic [mem_test_pkg::DATA_W-1:0]   checksum_o
);

  localparam int CNT_W = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1;
  localparam int OFS_W = mem_test_pkg::ADDR_W - mem_test_pkg::ID_W;
  localparam logic [CNT_W-1:0] LAST = CNT_W'(NUM_WORDS - 1);

  typedef enum logic [1:0] {
    SEND_IDLE,
    SEND_STORE,
    SEND_LOAD
  } send_state_e;

  typedef enum logic {
    RECV_IDLE,
    RECV_DATA
  } recv_state_e;

  send_state_e send_state_r, send_state_n;
  recv_state_e recv_state_r, recv_state_n;
  logic [CNT_W-1:0] send_cnt_r, send_cnt_n;
  logic [CNT_W-1:0] recv_cnt_r, recv_cnt_n;

  logic [mem_test_pkg::DATA_W-1:0] base_r;
  logic [mem_test_pkg::DATA_W-1:0] expect_data;
  logic [mem_test_pkg::DATA_W-1:0] checksum_r;
  logic [7:0]                      mismatch_r;
  logic                            done_r;
  logic                            resp_take;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sender.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    send_state_n = send_state_r;
    send_cnt_n   = send_cnt_r;
    req_valid_o  = 1'b0;
    req_o.op     = mem_test_pkg::OP_LOAD;
    req_o.src_id = mem_test_pkg::ID_W'(MASTER_ID);
    req_o.addr   = {mem_test_pkg::ID_W'(MASTER_ID), OFS_W'(send_cnt_r)};
    req_o.data   = base_r + mem_test_pkg::DATA_W'(send_cnt_r);
    case (send_state_r)
      SEND_STORE: begin
        req_valid_o = 1'b1;
        req_o.op    = mem_test_pkg::OP_STORE;
        if (req_ready_i) begin
          send_cnt_n   = (send_cnt_r == LAST) ? '0 : send_cnt_r + 1'b1;
          send_state_n = (send_cnt_r == LAST) ? SEND_LOAD : SEND_STORE;
        end
      end
      SEND_LOAD: begin
        req_valid_o = 1'b1;
        if (req_ready_i) begin
          send_cnt_n   = (send_cnt_r == LAST) ? '0 : send_cnt_r + 1'b1;
          send_state_n = (send_cnt_r == LAST) ? SEND_IDLE : SEND_LOAD;
        end
      end
      default: begin
        if (start_i) begin
          send_cnt_n   = '0;
          send_state_n = SEND_STORE;
        end
      end
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Receiver.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign resp_ready_o = 1'b1;
  assign resp_take    = resp_valid_i && (recv_state_r == RECV_DATA);
  assign expect_data  = base_r + mem_test_pkg::DATA_W'(recv_cnt_r);

  always_comb begin
    recv_state_n = recv_state_r;
    recv_cnt_n   = recv_cnt_r;
    if (recv_state_r == RECV_IDLE) begin
      if (start_i) begin
        recv_cnt_n   = '0;
        recv_state_n = RECV_DATA;
      end
    end else if (resp_take) begin
      recv_cnt_n   = (recv_cnt_r == LAST) ? '0 : recv_cnt_r + 1'b1;
      recv_state_n = (recv_cnt_r == LAST) ? RECV_IDLE : RECV_DATA;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      send_state_r <= SEND_IDLE;
      recv_state_r <= RECV_IDLE;
      send_cnt_r   <= '0;
      recv_cnt_r   <= '0;
      done_r       <= 1'b0;
      mismatch_r   <= '0;
      checksum_r   <= '0;
    end else begin
      send_state_r <= send_state_n;
      recv_state_r <= recv_state_n;
      send_cnt_r   <= send_cnt_n;
      recv_cnt_r   <= recv_cnt_n;
      if (start_i) begin
        done_r     <= 1'b0;
        mismatch_r <= '0;
        checksum_r <= '0;
      end else if (resp_take) begin
        checksum_r <= checksum_r + resp_i.data;
        if (resp_i.data != expect_data) mismatch_r <= mismatch_r + 1'b1;
        if (recv_cnt_r == LAST) done_r <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) base_r <= base_i;
  end

  assign busy_o     = (send_state_r != SEND_IDLE) || (recv_state_r != RECV_IDLE);
  assign done_o     = done_r;
  assign mismatch_o = mismatch_r;
  assign checksum_o = checksum_r;

  // Replies only while receiving, and only our own.
  a_resp_expected: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_valid_i |-> (recv_state_r == RECV_DATA) &&
                     (resp_i.src_id == mem_test_pkg::ID_W'(MASTER_ID)));

endmodule

`default_nettype wire

/* src/test_launcher.sv */
`timescale 1ns/10ps
`default_nettype none

module test_launcher #(
  parameter int NUM_MASTERS = 4
) (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              cmd_req_i,
  input  mem_test_pkg::test_cmd_s           cmd_i,
  output logic                              cmd_ack_o,
  input  logic [NUM_MASTERS-1:0]            busy_i,
  output logic [NUM_MASTERS-1:0]            start_o,
  output logic [mem_test_pkg::DATA_W-1:0]   base_o
);

  typedef enum logic [1:0] {
    L_IDLE,
    L_ACKED,
    L_RELEASED
  } launch_state_e;

  launch_state_e state_r, state_n;

  logic [NUM_MASTERS-1:0]           target_oh;
  logic                             target_busy;
  logic                             launch;
  logic [NUM_MASTERS-1:0]           start_r;
  logic [mem_test_pkg::DATA_W-1:0]  base_r;

  assign target_oh   = NUM_MASTERS'(1) << cmd_i.target;
  assign target_busy = |(target_oh & busy_i);

  // Hold off the ack until the target is free.
  assign launch = (state_r == L_IDLE) && cmd_req_i && !target_busy;

  always_comb begin
    state_n = state_r;
    case (state_r)
      L_IDLE:   if (launch) state_n = L_ACKED;
      L_ACKED:  if (!cmd_req_i) state_n = L_RELEASED;
      default:  state_n = L_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= L_IDLE;
      start_r <= '0;
    end else begin
      state_r <= state_n;
      start_r <= launch ? target_oh : '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (launch) base_r <= cmd_i.base;
  end

  assign cmd_ack_o = (state_r == L_ACKED);
  assign start_o   = start_r;
  assign base_o    = base_r;

  // A running master must never be restarted.
  a_start_idle: assert property (@(posedge clk_i) disable iff (reset_i)
    (start_o & busy_i) == '0);

endmodule

`default_nettype wire

/* src/mem_test_pkg.sv */
`default_nettype none

package mem_test_pkg;

  // Sizes shared by every block.
  localparam int ID_W   = 2;
  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;

  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } mem_op_e;

  // Request toward the bank.
  typedef struct packed {
    mem_op_e            op;
    logic [ID_W-1:0]    src_id;
    logic [ADDR_W-1:0]  addr;
    logic [DATA_W-1:0]  data;
  } mem_req_s;

  // Load reply from the bank.
  typedef struct packed {
    logic [ID_W-1:0]    src_id;
    logic [DATA_W-1:0]  data;
  } mem_resp_s;

  // External start command.
  typedef struct packed {
    logic [ID_W-1:0]    target;
    logic [DATA_W-1:0]  base;
  } test_cmd_s;

endpackage

`default_nettype wire
